//--- sim.f
design/pio_pkg.sv
design/ram_1r1w.sv
design/pio_rw_mem.sv
design/pio_bus_ctrl.sv
design/pio_mem_top.sv
verification/tb_pio_mem.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and check the log for the pass line.
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pio_mem -f sim.f \
	-o tb_pio_mem > build.log 2>&1 \
	&& ./obj_dir/tb_pio_mem > sim.log 2>&1
grep -qx 'Result: PASSED' sim.log \
	&& echo "simulation ok" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- verification/tb_pio_mem.sv
// app and pio reads only target entries written earlier in the run, since ram contents start undefined.
`timescale 1ns/1ps

module tb_pio_mem import pio_pkg::*; ();

	localparam int TIMEOUT = 64; // cycles allowed per wait.
	localparam int QN      = 16; // expected-read fifo depth.

	logic       clk;
	logic       arst_n;
	pio_addr_t  pio_addr;
	pio_word_t  pio_wdata;
	logic       pio_rd;
	logic       pio_wr;
	logic       pio_ack;
	pio_word_t  pio_rdata;
	logic       lut_rd;
	lut_addr_t  lut_raddr;
	logic       lut_wr;
	lut_addr_t  lut_waddr;
	lut_word_t  lut_wdata;
	logic       lut_ack;
	lut_word_t  lut_rdata;
	logic       stat_rd;
	stat_addr_t stat_raddr;
	logic       stat_wr;
	stat_addr_t stat_waddr;
	stat_word_t stat_wdata;
	logic       stat_ack;
	stat_word_t stat_rdata;

	// reference model of both tables.
	lut_word_t  lut_model [0:(1<<LUT_DEPTH_NBITS)-1];
	stat_word_t stat_model [0:(1<<STAT_DEPTH_NBITS)-1];

	// expected app reads pushed at the strobe and popped on the ack.
	lut_word_t   lut_exp_data [0:QN-1];
	int unsigned lut_exp_cyc [0:QN-1];
	int unsigned lut_wp = 0;
	int unsigned lut_rp = 0;
	stat_word_t  stat_exp_data [0:QN-1];
	int unsigned stat_exp_cyc [0:QN-1];
	int unsigned stat_wp = 0;
	int unsigned stat_rp = 0;
	logic        lut_due;  // an ack is due this cycle.
	logic        stat_due;

	// pio side.
	logic        pio_busy = 1'b0;   // request issued, ack not yet over.
	logic        pio_exp_rd = 1'b0;
	pio_word_t   pio_exp_data = '0;
	int unsigned ack_run;           // cycles pio_ack has been high.
	int unsigned cyc = 0;           // free-running cycle count.

	pio_mem_top u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.pio_addr   (pio_addr),
		.pio_wdata  (pio_wdata),
		.pio_rd     (pio_rd),
		.pio_wr     (pio_wr),
		.pio_ack    (pio_ack),
		.pio_rdata  (pio_rdata),
		.lut_rd     (lut_rd),
		.lut_raddr  (lut_raddr),
		.lut_wr     (lut_wr),
		.lut_waddr  (lut_waddr),
		.lut_wdata  (lut_wdata),
		.lut_ack    (lut_ack),
		.lut_rdata  (lut_rdata),
		.stat_rd    (stat_rd),
		.stat_raddr (stat_raddr),
		.stat_wr    (stat_wr),
		.stat_waddr (stat_waddr),
		.stat_wdata (stat_wdata),
		.stat_ack   (stat_ack),
		.stat_rdata (stat_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period.
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (lut_ack) begin
			lut_rp <= lut_rp + 1;
		end
		if (stat_ack) begin
			stat_rp <= stat_rp + 1;
		end
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_run <= 0;
		end else begin
			ack_run <= pio_ack ? ack_run + 1 : 0;
		end
	end

	// app ack exactly 3 cycles after its strobe.
	assign lut_due  = (lut_rp != lut_wp) && (cyc == lut_exp_cyc[lut_rp % QN] + 3);
	assign stat_due = (stat_rp != stat_wp) && (cyc == stat_exp_cyc[stat_rp % QN] + 3);

	lut_ack_cycle: assert property (@(posedge clk) disable iff (!arst_n) lut_ack == lut_due)
		else report_mismatch("lut_ack", 32'(lut_due), 32'(lut_ack));
	lut_rdata_value: assert property (@(posedge clk) disable iff (!arst_n)
		lut_ack |-> (lut_rdata == lut_exp_data[lut_rp % QN]))
		else report_mismatch("lut_rdata", 32'(lut_exp_data[lut_rp % QN]), 32'(lut_rdata));
	stat_ack_cycle: assert property (@(posedge clk) disable iff (!arst_n) stat_ack == stat_due)
		else report_mismatch("stat_ack", 32'(stat_due), 32'(stat_ack));
	stat_rdata_value: assert property (@(posedge clk) disable iff (!arst_n)
		stat_ack |-> (stat_rdata == stat_exp_data[stat_rp % QN]))
		else report_mismatch("stat_rdata", stat_exp_data[stat_rp % QN], stat_rdata);

	// pio ack only for a request and one pio period long.
	pio_ack_owner: assert property (@(posedge clk) disable iff (!arst_n) pio_ack |-> pio_busy)
		else report_mismatch("pio_ack", 32'h0, 32'h1);
	pio_ack_max: assert property (@(posedge clk) disable iff (!arst_n)
		pio_ack |-> (ack_run < PIO_DIV))
		else report_mismatch("pio_ack length", 32'(PIO_DIV), 32'(ack_run + 1));
	pio_ack_min: assert property (@(posedge clk) disable iff (!arst_n)
		(!pio_ack && ack_run != 0) |-> (ack_run == PIO_DIV))
		else report_mismatch("pio_ack length", 32'(PIO_DIV), 32'(ack_run));
	pio_rdata_value: assert property (@(posedge clk) disable iff (!arst_n)
		(pio_ack && pio_exp_rd) |-> (pio_rdata == pio_exp_data))
		else report_mismatch("pio_rdata", pio_exp_data, pio_rdata);

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("** Error at %0t ns: %s expected 0x%08h, actual 0x%08h",
			$time, name, exp_val, act_val);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic stop_run(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	// one cycle on and strobes drop 1 ns after the edge.
	task automatic advance();
		@(posedge clk);
		#1;
		pio_rd  = 1'b0;
		pio_wr  = 1'b0;
		lut_rd  = 1'b0;
		lut_wr  = 1'b0;
		stat_rd = 1'b0;
		stat_wr = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) advance();
	endtask

	function automatic pio_addr_t lut_pio_addr(input lut_addr_t idx);
		pio_addr_t a;
		a = '0;
		a[PIO_REGION_LSB +: PIO_REGION_NBITS] = LUT_REGION;
		a[LUT_DEPTH_NBITS+1:2] = idx; // word index above the byte offset.
		return a;
	endfunction

	function automatic pio_addr_t stat_pio_addr(input stat_addr_t idx);
		pio_addr_t a;
		a = '0;
		a[PIO_REGION_LSB +: PIO_REGION_NBITS] = STAT_REGION;
		a[STAT_DEPTH_NBITS+1:2] = idx;
		return a;
	endfunction

	function automatic pio_addr_t unmapped_addr(input logic [1:0] region, input logic [9:0] idx);
		pio_addr_t a;
		a = '0;
		a[PIO_REGION_LSB +: PIO_REGION_NBITS] = region; // 2 or 3.
		a[11:2] = idx;
		return a;
	endfunction

	// raise a pio strobe for the current cycle.
	task automatic pio_start(input logic is_rd, input pio_addr_t addr, input pio_word_t data,
		input pio_word_t exp_data);
		pio_addr     = addr;
		pio_wdata    = data;
		pio_rd       = is_rd;
		pio_wr       = ~is_rd;
		pio_exp_rd   = is_rd;
		pio_exp_data = exp_data;
		pio_busy     = 1'b1;
	endtask

	task automatic wait_pio_ack();
		int n;
		n = 0;
		while (!pio_ack && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!pio_ack) begin
			stop_run("no pio_ack within the timeout");
		end
		n = 0;
		while (pio_ack && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (pio_ack) begin
			stop_run("pio_ack never dropped");
		end
		pio_busy = 1'b0;
	endtask

	task automatic pio_write(input pio_addr_t addr, input pio_word_t data);
		pio_start(1'b0, addr, data, 32'h0);
		advance();
		wait_pio_ack();
	endtask

	task automatic pio_read(input pio_addr_t addr, input pio_word_t exp_data);
		pio_start(1'b1, addr, 32'h0, exp_data);
		advance();
		wait_pio_ack();
	endtask

	// app strobes; a read set before a write in the same cycle sees old data.
	task automatic lut_rd_set(input lut_addr_t a);
		lut_rd                    = 1'b1;
		lut_raddr                 = a;
		lut_exp_data[lut_wp % QN] = lut_model[a];
		lut_exp_cyc[lut_wp % QN]  = cyc;
		lut_wp++;
	endtask

	task automatic lut_wr_set(input lut_addr_t a, input lut_word_t d);
		lut_wr       = 1'b1;
		lut_waddr    = a;
		lut_wdata    = d;
		lut_model[a] = d;
	endtask

	task automatic stat_rd_set(input stat_addr_t a);
		stat_rd                     = 1'b1;
		stat_raddr                  = a;
		stat_exp_data[stat_wp % QN] = stat_model[a];
		stat_exp_cyc[stat_wp % QN]  = cyc;
		stat_wp++;
	endtask

	task automatic stat_wr_set(input stat_addr_t a, input stat_word_t d);
		stat_wr       = 1'b1;
		stat_waddr    = a;
		stat_wdata    = d;
		stat_model[a] = d;
	endtask

	task automatic drain_app();
		int n;
		n = 0;
		while ((lut_rp != lut_wp || stat_rp != stat_wp) && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (lut_rp != lut_wp || stat_rp != stat_wp) begin
			stop_run("application read acks missing after the timeout");
		end
	endtask

	initial begin
		lut_addr_t  la [0:3];
		stat_addr_t sa [0:3];
		lut_addr_t  lut_base;
		stat_addr_t stat_base;
		pio_word_t  w;

		void'($urandom(76267));
		arst_n     = 1'b0;
		pio_addr   = '0;
		pio_wdata  = '0;
		pio_rd     = 1'b0;
		pio_wr     = 1'b0;
		lut_rd     = 1'b0;
		lut_raddr  = '0;
		lut_wr     = 1'b0;
		lut_waddr  = '0;
		lut_wdata  = '0;
		stat_rd    = 1'b0;
		stat_raddr = '0;
		stat_wr    = 1'b0;
		stat_waddr = '0;
		stat_wdata = '0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		idle(12); // all acks stay low.

		// pio write then read back masked to 20 bits.
		for (int i = 0; i < 4; i++) begin
			la[i] = lut_addr_t'($urandom);
			w     = $urandom;
			pio_write(lut_pio_addr(la[i]), w);
			lut_model[la[i]] = w[LUT_WIDTH-1:0];
			pio_read(lut_pio_addr(la[i]), 32'(lut_model[la[i]]));
		end

		// app writes, app reads, pio reads of the same entries.
		lut_base  = lut_addr_t'($urandom);
		stat_base = stat_addr_t'($urandom);
		for (int i = 0; i < 4; i++) begin
			la[i] = lut_base + lut_addr_t'(i * 37); // distinct entries.
			sa[i] = stat_base + stat_addr_t'(i * 11);
			lut_wr_set(la[i], lut_word_t'($urandom));
			stat_wr_set(sa[i], $urandom);
			advance();
		end
		for (int i = 0; i < 4; i++) begin
			lut_rd_set(la[i]);
			stat_rd_set(sa[i]);
			advance();
		end
		drain_app();
		for (int i = 0; i < 4; i++) begin
			pio_read(lut_pio_addr(la[i]), 32'(lut_model[la[i]]));
			pio_read(stat_pio_addr(sa[i]), stat_model[sa[i]]);
		end

		// read-during-write on both tables while the pio write gets the free port.
		w = $urandom;
		lut_rd_set(la[0]);
		lut_wr_set(la[0], lut_word_t'($urandom));
		stat_rd_set(sa[0]);
		stat_wr_set(sa[0], $urandom);
		pio_start(1'b0, lut_pio_addr(la[1]), w, 32'h0);
		lut_model[la[1]] = w[LUT_WIDTH-1:0]; // no app write in flight.
		advance();
		wait_pio_ack();

		// pio write saved behind two app writes to the same entry.
		w = $urandom;
		lut_wr_set(la[2], lut_word_t'($urandom));
		advance();
		lut_wr_set(la[2], lut_word_t'($urandom));
		pio_start(1'b0, lut_pio_addr(la[2]), w, 32'h0);
		advance();
		wait_pio_ack();
		lut_model[la[2]] = w[LUT_WIDTH-1:0]; // saved write lands last.
		lut_rd_set(la[2]);
		advance();

		// pio read saved behind app reads of the same entry.
		lut_rd_set(la[3]);
		advance();
		lut_rd_set(la[1]);
		pio_start(1'b1, lut_pio_addr(la[1]), 32'h0, 32'(lut_model[la[1]]));
		advance();
		wait_pio_ack();

		// pio read beside an app write to the same entry.
		pio_start(1'b1, lut_pio_addr(la[3]), 32'h0, 32'(lut_model[la[3]]));
		lut_wr_set(la[3], lut_word_t'($urandom));
		advance();
		wait_pio_ack();

		// stat pio read saved behind app traffic.
		stat_rd_set(sa[0]);
		advance();
		stat_rd_set(sa[1]);
		stat_wr_set(sa[2], $urandom);
		pio_start(1'b1, stat_pio_addr(sa[3]), 32'h0, stat_model[sa[3]]);
		advance();
		wait_pio_ack();
		drain_app();
		for (int i = 0; i < 4; i++) begin
			pio_read(lut_pio_addr(la[i]), 32'(lut_model[la[i]]));
			pio_read(stat_pio_addr(sa[i]), stat_model[sa[i]]);
		end

		// stat pio writes acked but dropped.
		for (int i = 0; i < 2; i++) begin
			pio_write(stat_pio_addr(sa[i]), $urandom);
			pio_read(stat_pio_addr(sa[i]), stat_model[sa[i]]);
		end

		// unmapped regions answer with zero.
		for (int r = 2; r < 4; r++) begin
			pio_write(unmapped_addr(2'(r), 10'($urandom)), $urandom);
			pio_read(unmapped_addr(2'(r), 10'($urandom)), 32'h0);
		end
		pio_read(lut_pio_addr(la[0]), 32'(lut_model[la[0]])); // table untouched.

		drain_app();
		idle(4);
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- design/pio_mem_top.sv
// lookup table writable from both masters; statistics table is read-only from pio.
`timescale 1ns/1ps

module pio_mem_top import pio_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	// pio port.
	input  pio_addr_t  pio_addr,
	input  pio_word_t  pio_wdata,
	input  logic       pio_rd,
	input  logic       pio_wr,
	output logic       pio_ack,
	output pio_word_t  pio_rdata,
	// lookup table app port.
	input  logic       lut_rd,
	input  lut_addr_t  lut_raddr,
	input  logic       lut_wr,
	input  lut_addr_t  lut_waddr,
	input  lut_word_t  lut_wdata,
	output logic       lut_ack,
	output lut_word_t  lut_rdata,
	// statistics table app port.
	input  logic       stat_rd,
	input  stat_addr_t stat_raddr,
	input  logic       stat_wr,
	input  stat_addr_t stat_waddr,
	input  stat_word_t stat_wdata,
	output logic       stat_ack,
	output stat_word_t stat_rdata
);

	pio_addr_t reg_addr;
	pio_word_t reg_din;
	logic      reg_rd;
	logic      reg_wr;
	logic      lut_ms;
	logic      stat_ms;
	logic      clk_div;
	logic      lut_mem_ack;
	pio_word_t lut_mem_rdata;
	logic      stat_mem_ack;
	pio_word_t stat_mem_rdata;

	pio_bus_ctrl u_bus_ctrl (
		.clk            (clk),
		.arst_n         (arst_n),
		.pio_addr       (pio_addr),
		.pio_wdata      (pio_wdata),
		.pio_rd         (pio_rd),
		.pio_wr         (pio_wr),
		.pio_ack        (pio_ack),
		.pio_rdata      (pio_rdata),
		.reg_addr       (reg_addr),
		.reg_din        (reg_din),
		.reg_rd         (reg_rd),
		.reg_wr         (reg_wr),
		.lut_ms         (lut_ms),
		.stat_ms        (stat_ms),
		.clk_div        (clk_div),
		.lut_mem_ack    (lut_mem_ack),
		.lut_mem_rdata  (lut_mem_rdata),
		.stat_mem_ack   (stat_mem_ack),
		.stat_mem_rdata (stat_mem_rdata)
	);

	pio_rw_mem #(
		.WIDTH       (LUT_WIDTH),
		.DEPTH_NBITS (LUT_DEPTH_NBITS),
		.REG_WR_EN   (1'b1)
	) u_lut_mem (
		.clk           (clk),
		.arst_n        (arst_n),
		.clk_div       (clk_div),
		.reg_addr      (reg_addr),
		.reg_din       (reg_din),
		.reg_rd        (reg_rd),
		.reg_wr        (reg_wr),
		.reg_ms        (lut_ms),
		.app_mem_rd    (lut_rd),
		.app_mem_raddr (lut_raddr),
		.app_mem_wr    (lut_wr),
		.app_mem_waddr (lut_waddr),
		.app_mem_wdata (lut_wdata),
		.mem_ack       (lut_mem_ack),
		.mem_rdata     (lut_mem_rdata),
		.app_mem_ack   (lut_ack),
		.app_mem_rdata (lut_rdata)
	);

	// pio writes dropped, still acked.
	pio_rw_mem #(
		.WIDTH       (STAT_WIDTH),
		.DEPTH_NBITS (STAT_DEPTH_NBITS),
		.REG_WR_EN   (1'b0)
	) u_stat_mem (
		.clk           (clk),
		.arst_n        (arst_n),
		.clk_div       (clk_div),
		.reg_addr      (reg_addr),
		.reg_din       (reg_din),
		.reg_rd        (reg_rd),
		.reg_wr        (reg_wr),
		.reg_ms        (stat_ms),
		.app_mem_rd    (stat_rd),
		.app_mem_raddr (stat_raddr),
		.app_mem_wr    (stat_wr),
		.app_mem_waddr (stat_waddr),
		.app_mem_wdata (stat_wdata),
		.mem_ack       (stat_mem_ack),
		.mem_rdata     (stat_mem_rdata),
		.app_mem_ack   (stat_ack),
		.app_mem_rdata (stat_rdata)
	);

endmodule

//--- design/pio_bus_ctrl.sv
// one outstanding pio request at a time; unmapped regions ack with zero read data.
`timescale 1ns/1ps

module pio_bus_ctrl import pio_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  pio_addr_t pio_addr,
	input  pio_word_t pio_wdata,
	input  logic      pio_rd,
	input  logic      pio_wr,
	output logic      pio_ack,
	output pio_word_t pio_rdata,
	output pio_addr_t reg_addr,
	output pio_word_t reg_din,
	output logic      reg_rd,
	output logic      reg_wr,
	output logic      lut_ms,
	output logic      stat_ms,
	output logic      clk_div,
	input  logic      lut_mem_ack,
	input  pio_word_t lut_mem_rdata,
	input  logic      stat_mem_ack,
	input  pio_word_t stat_mem_rdata
);

	logic [PIO_DIV_NBITS-1:0]    div_cnt;    // free-running divider.
	logic                        pio_req;    // either strobe.
	logic [PIO_REGION_NBITS-1:0] region;
	logic                        unmapped;
	logic                        unmap_pend; // waiting for clk_div.
	logic                        unmap_ack;
	logic                        last_rd;    // outstanding request is a read.
	pio_addr_t                   addr_hold;  // kept for saved table accesses.
	pio_word_t                   din_hold;
	pio_word_t                   rdata_sel;
	pio_word_t                   rdata_hold;

	assign pio_req = pio_rd | pio_wr;
	assign clk_div = (div_cnt == PIO_DIV_NBITS'(PIO_DIV - 1)); // one cycle in PIO_DIV.

	// live address on the strobe, held copy afterwards.
	assign reg_addr = pio_req ? pio_addr : addr_hold;
	assign reg_din  = pio_req ? pio_wdata : din_hold;
	assign reg_rd   = pio_rd;
	assign reg_wr   = pio_wr;

	// region decode.
	assign region   = reg_addr[PIO_REGION_LSB +: PIO_REGION_NBITS];
	assign lut_ms   = (region == LUT_REGION);
	assign stat_ms  = (region == STAT_REGION);
	assign unmapped = ~lut_ms & ~stat_ms;

	// merge responses.
	assign pio_ack = lut_mem_ack | stat_mem_ack | unmap_ack;

	always_comb begin
		if (lut_mem_ack) begin
			rdata_sel = lut_mem_rdata;
		end else if (stat_mem_ack) begin
			rdata_sel = stat_mem_rdata;
		end else begin
			rdata_sel = '0; // unmapped.
		end
	end

	// only a read updates the returned data.
	assign pio_rdata = (pio_ack & last_rd) ? rdata_sel : rdata_hold;

	always_ff @(posedge clk) begin
		if (pio_req) begin
			addr_hold <= pio_addr;
			din_hold  <= pio_wdata;
		end
		rdata_hold <= pio_rdata;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt    <= '0;
			unmap_pend <= 1'b0;
			unmap_ack  <= 1'b0;
			last_rd    <= 1'b0;
		end else begin
			div_cnt <= clk_div ? '0 : div_cnt + 1'b1;
			if (pio_req) begin
				last_rd <= pio_rd;
			end

			// same pacing as a table's ack.
			if (pio_req & unmapped) begin
				unmap_pend <= 1'b1;
			end else if (clk_div) begin
				unmap_pend <= 1'b0;
			end
			if (clk_div) begin
				unmap_ack <= unmap_pend;
			end
		end
	end

endmodule

//--- design/pio_rw_mem.sv
// app access always owns the ram port; pio access waits for a free cycle, ack paced by clk_div.
`timescale 1ns/1ps

module pio_rw_mem import pio_pkg::*; #(
	parameter int WIDTH       = 20,
	parameter int DEPTH_NBITS = 10,
	parameter bit REG_WR_EN   = 1'b1
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   clk_div,
	input  pio_addr_t              reg_addr,
	input  pio_word_t              reg_din,
	input  logic                   reg_rd,
	input  logic                   reg_wr,
	input  logic                   reg_ms,
	input  logic                   app_mem_rd,
	input  logic [DEPTH_NBITS-1:0] app_mem_raddr,
	input  logic                   app_mem_wr,
	input  logic [DEPTH_NBITS-1:0] app_mem_waddr,
	input  logic [WIDTH-1:0]       app_mem_wdata,
	output logic                   mem_ack,
	output pio_word_t              mem_rdata,
	output logic                   app_mem_ack,
	output logic [WIDTH-1:0]       app_mem_rdata
);

	// app pipeline.
	logic                   app_rd_d1;
	logic                   app_rd_d2;
	logic                   app_wr_d1;
	logic [DEPTH_NBITS-1:0] app_raddr_d1;
	logic [DEPTH_NBITS-1:0] app_waddr_d1;
	logic [WIDTH-1:0]       app_wdata_d1;

	// pio side.
	logic                   pio_rd_req;   // new pio read for this table.
	logic                   pio_wr_req;   // new pio write for this table.
	logic                   rd_save;      // read lost to app, retry.
	logic                   wr_save;      // write lost to app, retry.
	logic                   rd_go;        // pio read owns the port now.
	logic                   wr_go;        // pio write owns the port now.
	logic                   rd_go_d1;     // ram dout valid for pio.
	logic                   ack_pend;     // done, waiting for clk_div.
	logic [DEPTH_NBITS-1:0] pio_word_idx; // word index from byte address.

	// ram port.
	logic                   ram_wr;
	logic [DEPTH_NBITS-1:0] ram_raddr;
	logic [DEPTH_NBITS-1:0] ram_waddr;
	logic [WIDTH-1:0]       ram_wdata;
	logic [WIDTH-1:0]       ram_rdata;
	pio_word_t              ram_rdata_ext;

	assign pio_rd_req   = reg_ms & reg_rd;
	assign pio_wr_req   = reg_ms & reg_wr;
	assign pio_word_idx = reg_addr[DEPTH_NBITS+1:2]; // drop byte offset.

	// pio goes only when the delayed app access leaves the port idle.
	assign rd_go = ~app_rd_d1 & (pio_rd_req | rd_save);
	assign wr_go = ~app_wr_d1 & (pio_wr_req | wr_save);

	// app wins the muxes.
	assign ram_raddr = app_rd_d1 ? app_raddr_d1 : pio_word_idx;
	assign ram_waddr = app_wr_d1 ? app_waddr_d1 : pio_word_idx;
	assign ram_wdata = app_wr_d1 ? app_wdata_d1 : reg_din[WIDTH-1:0];
	assign ram_wr    = app_wr_d1 | (REG_WR_EN & wr_go); // disabled pio write still acks.

	// zero-extend to a pio word.
	always_comb begin
		ram_rdata_ext              = '0;
		ram_rdata_ext[WIDTH-1:0]   = ram_rdata;
	end

	always_ff @(posedge clk) begin
		app_raddr_d1  <= app_mem_raddr;
		app_waddr_d1  <= app_mem_waddr;
		app_wdata_d1  <= app_mem_wdata;
		app_mem_rdata <= ram_rdata; // second register on the app read path.
		if (rd_go_d1) begin
			mem_rdata <= ram_rdata_ext; // held until next pio read.
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			app_rd_d1   <= 1'b0;
			app_rd_d2   <= 1'b0;
			app_wr_d1   <= 1'b0;
			app_mem_ack <= 1'b0;
			rd_save     <= 1'b0;
			wr_save     <= 1'b0;
			rd_go_d1    <= 1'b0;
			ack_pend    <= 1'b0;
			mem_ack     <= 1'b0;
		end else begin
			app_rd_d1   <= app_mem_rd;
			app_rd_d2   <= app_rd_d1;
			app_wr_d1   <= app_mem_wr;
			app_mem_ack <= app_rd_d2; // 3 cycles after strobe.
			rd_go_d1    <= rd_go;

			// park a colliding read.
			if (app_rd_d1 & pio_rd_req) begin
				rd_save <= 1'b1;
			end else if (rd_go) begin
				rd_save <= 1'b0;
			end

			// park a colliding write.
			if (app_wr_d1 & pio_wr_req) begin
				wr_save <= 1'b1;
			end else if (wr_go) begin
				wr_save <= 1'b0;
			end

			// set on completion, drained by the next clk_div.
			if (wr_go | rd_go_d1) begin
				ack_pend <= 1'b1;
			end else if (clk_div) begin
				ack_pend <= 1'b0;
			end

			// one full pio period high.
			if (clk_div) begin
				mem_ack <= ack_pend;
			end
		end
	end

	ram_1r1w #(
		.WIDTH       (WIDTH),
		.DEPTH_NBITS (DEPTH_NBITS)
	) u_ram (
		.clk   (clk),
		.wr    (ram_wr),
		.raddr (ram_raddr),
		.waddr (ram_waddr),
		.din   (ram_wdata),
		.dout  (ram_rdata)
	);

endmodule

//--- design/ram_1r1w.sv
// registered read, old data on same-address read-during-write; contents undefined at power-up.
`timescale 1ns/1ps

module ram_1r1w #(
	parameter int WIDTH       = 20,
	parameter int DEPTH_NBITS = 10
) (
	input  logic                   clk,
	input  logic                   wr,
	input  logic [DEPTH_NBITS-1:0] raddr,
	input  logic [DEPTH_NBITS-1:0] waddr,
	input  logic [WIDTH-1:0]       din,
	output logic [WIDTH-1:0]       dout
);

	logic [WIDTH-1:0] mem [0:(1<<DEPTH_NBITS)-1]; // storage array.

	// write and read share the edge.
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
		dout <= mem[raddr]; // nonblocking, so old data on collision.
	end

endmodule

//--- design/pio_pkg.sv
// pio word is 32 bits, byte addressed, no byte enables; region field at addr[13:12].
package pio_pkg;

	// pio bus geometry.
	localparam int PIO_NBITS = 32; // data and address width.

	typedef logic [PIO_NBITS-1:0] pio_word_t; // pio data.
	typedef logic [PIO_NBITS-1:0] pio_addr_t; // byte address, word index in [31:2].

	// region map.
	localparam int PIO_REGION_LSB   = 12;
	localparam int PIO_REGION_NBITS = 2; // regions 2 and 3 unmapped.

	localparam logic [PIO_REGION_NBITS-1:0] LUT_REGION  = 2'd0;
	localparam logic [PIO_REGION_NBITS-1:0] STAT_REGION = 2'd1;

	// pio-rate strobe, clk cycles per period.
	localparam int PIO_DIV       = 4;
	localparam int PIO_DIV_NBITS = $clog2(PIO_DIV);

	// lookup table, 1024 x 20.
	localparam int LUT_WIDTH       = 20;
	localparam int LUT_DEPTH_NBITS = 10;

	typedef logic [LUT_WIDTH-1:0]       lut_word_t;
	typedef logic [LUT_DEPTH_NBITS-1:0] lut_addr_t;

	// statistics table, 256 x 32.
	localparam int STAT_WIDTH       = 32;
	localparam int STAT_DEPTH_NBITS = 8;

	typedef logic [STAT_WIDTH-1:0]       stat_word_t;
	typedef logic [STAT_DEPTH_NBITS-1:0] stat_addr_t;

endpackage
